//--- design/npc_params.svh
// RV64 only; the data memory is tiny and word-indexed by address bits 7:3, with no bounds check.
`ifndef NPC_PARAMS_SVH
`define NPC_PARAMS_SVH

`default_nettype none

// integer data width.
`define NPC_XLEN 64

// architectural integer registers, x0 included.
`define NPC_NREGS 32

// data memory depth in 64-bit words; bits 2:0 of an address select the byte lane.
`define NPC_DMEM_WORDS 32

// PC of the first accepted instruction.
`define NPC_RESET_PC 64'h0000_0000_8000_0000

`default_nettype wire

`endif

//--- design/npc_pkg.sv
// stage payloads assume RV64I with 32 registers; rd fields take their width from the register count.
`include "npc_params.svh"
`default_nettype none

package npc_pkg;

  localparam int unsigned REG_AW = $clog2(`NPC_NREGS);

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_PASSB
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_NONE, MEM_LD, MEM_LW, MEM_LBU, MEM_SD, MEM_SW, MEM_SB
  } mem_op_e;

  // decode to execute.
  typedef struct packed {
    logic [`NPC_XLEN-1:0] op_a;
    logic [`NPC_XLEN-1:0] op_b;
    logic [`NPC_XLEN-1:0] st_data;
    alu_op_e              alu_op;
    logic                 word;    // sign-extend the low 32 bits of the result.
    mem_op_e              mem_op;
    logic [REG_AW-1:0]    rd;
    logic                 we;
    logic                 illegal;
  } dec_t;

  // execute to memory.
  typedef struct packed {
    logic [`NPC_XLEN-1:0] res;     // ALU result, or the address for loads and stores.
    logic [`NPC_XLEN-1:0] st_data;
    mem_op_e              mem_op;
    logic [REG_AW-1:0]    rd;
    logic                 we;
    logic                 illegal;
  } ex_t;

  // writeback record, one per instruction in program order.
  typedef struct packed {
    logic [REG_AW-1:0]    rd;
    logic [`NPC_XLEN-1:0] data;
    logic                 we;
    logic                 illegal;
  } wb_t;

endpackage

`default_nettype wire

//--- design/npc_pipe_reg.sv
// one-entry stage register; ready is combinational from the downstream ready to keep full rate.
`timescale 1ns/1ps
`default_nettype none

module npc_pipe_reg #(
  parameter type T = logic
) (
  input  wire  i_clk,
  input  wire  i_rst,
  input  wire  i_valid,
  output logic o_ready,
  input  wire  T i_data,
  output logic o_valid,
  input  wire  i_ready,
  output T     o_data
);

  logic full_q;
  T     data_q;

  // take a new entry when empty or when the held one leaves this cycle.
  assign o_ready = ~full_q | i_ready;
  assign o_valid = full_q;
  assign o_data  = data_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      full_q <= 1'b0;
    end else if (o_ready) begin
      full_q <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      data_q <= i_data;
    end
  end

endmodule

`default_nettype wire

//--- design/npc_idu.sv
// decodes a subset of RV64I only; no forwarding, so any pending write to a used register stalls.
`timescale 1ns/1ps
`include "npc_params.svh"
`default_nettype none

module npc_idu (
  input  wire                  i_clk,
  input  wire                  i_rst,
  input  wire                  i_inst_valid,
  output logic                 o_inst_ready,
  input  wire  [31:0]          i_inst,
  input  wire  npc_pkg::wb_t   i_wb,
  input  wire                  i_wb_fire,
  output logic                 o_valid,
  input  wire                  i_ready,
  output npc_pkg::dec_t        o_dec
);

  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OP32  = 7'b0111011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef enum logic [1:0] {A_RS1, A_ZERO, A_PC} a_sel_e;

  logic [`NPC_XLEN-1:0]      regs_q [`NPC_NREGS];
  logic [`NPC_NREGS-1:0]     busy_q;
  logic [`NPC_XLEN-1:0]      pc_q;
  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic [npc_pkg::REG_AW-1:0] rs1, rs2, rd;
  logic [`NPC_XLEN-1:0]      imm_i, imm_s, imm_u, imm;
  npc_pkg::alu_op_e          d_alu;
  npc_pkg::mem_op_e          d_mem;
  logic                      d_word, d_we, d_ill, use_rs1, use_rs2, b_reg;
  a_sel_e                    a_sel;
  logic                      hazard, fire;

  assign opcode = i_inst[6:0];
  assign rd     = i_inst[11:7];
  assign funct3 = i_inst[14:12];
  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};

  always_comb begin
    d_alu   = npc_pkg::ALU_ADD;
    d_mem   = npc_pkg::MEM_NONE;
    d_word  = 1'b0;
    d_we    = 1'b1;
    d_ill   = 1'b0;
    use_rs1 = 1'b1;
    use_rs2 = 1'b0;
    b_reg   = 1'b0;
    a_sel   = A_RS1;
    imm     = imm_i;
    case (opcode)
      OPC_LUI: begin
        a_sel   = A_ZERO;
        use_rs1 = 1'b0;
        imm     = imm_u;
      end
      OPC_AUIPC: begin
        a_sel   = A_PC;
        use_rs1 = 1'b0;
        imm     = imm_u;
      end
      OPC_IMM: begin
        case (funct3)
          3'b000: d_alu = npc_pkg::ALU_ADD;
          3'b001: d_alu = npc_pkg::ALU_SLL;
          3'b101: d_alu = npc_pkg::ALU_SRL;
          default: d_ill = 1'b1;
        endcase
        // RV64 shifts keep a 6-bit shamt, so only bits 31:26 must be zero.
        if (funct3 != 3'b000 && i_inst[31:26] != 6'b0) d_ill = 1'b1;
      end
      OPC_OP: begin
        use_rs2 = 1'b1;
        b_reg   = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: d_alu = npc_pkg::ALU_ADD;
          {7'h20, 3'b000}: d_alu = npc_pkg::ALU_SUB;
          {7'h00, 3'b010}: d_alu = npc_pkg::ALU_SLT;
          {7'h00, 3'b011}: d_alu = npc_pkg::ALU_SLTU;
          {7'h00, 3'b100}: d_alu = npc_pkg::ALU_XOR;
          {7'h00, 3'b110}: d_alu = npc_pkg::ALU_OR;
          {7'h00, 3'b111}: d_alu = npc_pkg::ALU_AND;
          default: d_ill = 1'b1;
        endcase
      end
      OPC_OP32: begin
        use_rs2 = 1'b1;
        b_reg   = 1'b1;
        d_word  = 1'b1;
        if (funct7 != 7'h00 || funct3 != 3'b000) d_ill = 1'b1;
      end
      OPC_LOAD: begin
        case (funct3)
          3'b011: d_mem = npc_pkg::MEM_LD;
          3'b010: d_mem = npc_pkg::MEM_LW;
          3'b100: d_mem = npc_pkg::MEM_LBU;
          default: d_ill = 1'b1;
        endcase
      end
      OPC_STORE: begin
        d_we    = 1'b0;
        use_rs2 = 1'b1;
        imm     = imm_s;
        case (funct3)
          3'b011: d_mem = npc_pkg::MEM_SD;
          3'b010: d_mem = npc_pkg::MEM_SW;
          3'b000: d_mem = npc_pkg::MEM_SB;
          default: d_ill = 1'b1;
        endcase
      end
      default: d_ill = 1'b1;
    endcase
    if (d_ill) begin // illegal encodings travel as a no-op record.
      d_alu   = npc_pkg::ALU_PASSB;
      d_mem   = npc_pkg::MEM_NONE;
      d_word  = 1'b0;
      d_we    = 1'b0;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
    end
  end

  assign hazard = (use_rs1 && busy_q[rs1]) || (use_rs2 && busy_q[rs2]) || (d_we && busy_q[rd]);
  assign o_valid      = i_inst_valid && !hazard;
  assign o_inst_ready = i_ready && !hazard;
  assign fire         = i_inst_valid && o_inst_ready;

  always_comb begin
    case (a_sel)
      A_ZERO:  o_dec.op_a = '0;
      A_PC:    o_dec.op_a = pc_q;
      default: o_dec.op_a = regs_q[rs1];
    endcase
    o_dec.op_b    = b_reg ? regs_q[rs2] : imm;
    o_dec.st_data = regs_q[rs2];
    o_dec.alu_op  = d_alu;
    o_dec.word    = d_word;
    o_dec.mem_op  = d_mem;
    o_dec.rd      = rd;
    o_dec.we      = d_we;
    o_dec.illegal = d_ill;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q   <= `NPC_RESET_PC;
      busy_q <= '0;
      for (int i = 0; i < `NPC_NREGS; i++) regs_q[i] <= '0;
    end else begin
      if (fire) pc_q <= pc_q + 64'd4;
      if (i_wb_fire && i_wb.we && i_wb.rd != '0) begin
        regs_q[i_wb.rd] <= i_wb.data;
        busy_q[i_wb.rd] <= 1'b0;
      end
      if (fire && d_we && rd != '0) busy_q[rd] <= 1'b1; // x0 never goes busy.
    end
  end

endmodule

`default_nettype wire

//--- design/npc_exu.sv
// stateless ALU stage; only ADDW uses the word path, and shifts take the low 6 bits of b.
`timescale 1ns/1ps
`include "npc_params.svh"
`default_nettype none

module npc_exu (
  input  wire                 i_valid,
  output logic                o_ready,
  input  wire  npc_pkg::dec_t i_dec,
  output logic                o_valid,
  input  wire                 i_ready,
  output npc_pkg::ex_t        o_ex
);

  logic [`NPC_XLEN-1:0] a, b, alu;
  logic [5:0]           shamt;

  assign a     = i_dec.op_a;
  assign b     = i_dec.op_b;
  assign shamt = b[5:0];

  always_comb begin
    case (i_dec.alu_op)
      npc_pkg::ALU_SUB:   alu = a - b;
      npc_pkg::ALU_AND:   alu = a & b;
      npc_pkg::ALU_OR:    alu = a | b;
      npc_pkg::ALU_XOR:   alu = a ^ b;
      npc_pkg::ALU_SLT:   alu = {{(`NPC_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      npc_pkg::ALU_SLTU:  alu = {{(`NPC_XLEN-1){1'b0}}, a < b};
      npc_pkg::ALU_SLL:   alu = a << shamt;
      npc_pkg::ALU_SRL:   alu = a >> shamt;
      npc_pkg::ALU_PASSB: alu = b;
      default:            alu = a + b; // also the load and store address.
    endcase
  end

  always_comb begin
    if (i_dec.word) begin
      o_ex.res = {{32{alu[31]}}, alu[31:0]};
    end else begin
      o_ex.res = alu;
    end
    o_ex.st_data = i_dec.st_data;
    o_ex.mem_op  = i_dec.mem_op;
    o_ex.rd      = i_dec.rd;
    o_ex.we      = i_dec.we;
    o_ex.illegal = i_dec.illegal;
  end

  // no state here, so the handshake runs straight through.
  assign o_valid = i_valid;
  assign o_ready = i_ready;

endmodule

`default_nettype wire

//--- design/npc_lsu.sv
// alignment is not checked; LW and SW use address bit 2, SB and LBU bits 2:0, LD and SD neither.
`timescale 1ns/1ps
`include "npc_params.svh"
`default_nettype none

module npc_lsu (
  input  wire                i_clk,
  input  wire                i_rst,
  input  wire                i_valid,
  output logic               o_ready,
  input  wire  npc_pkg::ex_t i_ex,
  output logic               o_wb_valid,
  input  wire                i_wb_ready,
  output npc_pkg::wb_t       o_wb
);

  localparam int unsigned AW = $clog2(`NPC_DMEM_WORDS);

  logic [`NPC_XLEN-1:0] mem_q [`NPC_DMEM_WORDS];
  logic [AW-1:0]        widx;
  logic [2:0]           lane;
  logic [`NPC_XLEN-1:0] rword, ld_data, wdata;
  logic [7:0]           be;
  logic                 is_load, is_store, fire, full_q;
  npc_pkg::wb_t         wb_q;

  assign widx  = i_ex.res[AW+2:3];
  assign lane  = i_ex.res[2:0];
  assign rword = mem_q[widx];

  assign is_load  = i_ex.mem_op inside {npc_pkg::MEM_LD, npc_pkg::MEM_LW, npc_pkg::MEM_LBU};
  assign is_store = i_ex.mem_op inside {npc_pkg::MEM_SD, npc_pkg::MEM_SW, npc_pkg::MEM_SB};

  assign o_ready = ~full_q | i_wb_ready;
  assign fire    = i_valid && o_ready;

  always_comb begin
    case (i_ex.mem_op)
      npc_pkg::MEM_SW: begin
        be    = 8'h0f << {lane[2], 2'b00};
        wdata = {2{i_ex.st_data[31:0]}};
      end
      npc_pkg::MEM_SB: begin
        be    = 8'h01 << lane;
        wdata = {8{i_ex.st_data[7:0]}};
      end
      default: begin
        be    = 8'hff;
        wdata = i_ex.st_data;
      end
    endcase
  end

  always_comb begin
    case (i_ex.mem_op)
      npc_pkg::MEM_LW:  ld_data = lane[2] ? {{32{rword[63]}}, rword[63:32]}
                                          : {{32{rword[31]}}, rword[31:0]};
      npc_pkg::MEM_LBU: ld_data = {56'b0, rword[{lane, 3'b000} +: 8]};
      default:          ld_data = rword;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `NPC_DMEM_WORDS; i++) mem_q[i] <= '0;
    end else if (fire && is_store) begin
      for (int b = 0; b < 8; b++) begin
        if (be[b]) mem_q[widx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      full_q <= 1'b0;
    end else if (o_ready) begin
      full_q <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (fire) begin
      wb_q.rd      <= i_ex.rd;
      wb_q.data    <= is_load ? ld_data : i_ex.res;
      wb_q.we      <= i_ex.we && !is_store && !i_ex.illegal;
      wb_q.illegal <= i_ex.illegal;
    end
  end

  assign o_wb_valid = full_q;
  assign o_wb       = wb_q;

endmodule

`default_nettype wire

//--- design/npc_core.sv
// instructions stream in with no fetch or branches; each one yields a writeback record in order.
`timescale 1ns/1ps
`include "npc_params.svh"
`default_nettype none

module npc_core (
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire                        i_inst_valid,
  input  wire  [31:0]                i_inst,
  output logic                       o_inst_ready,
  output logic                       o_wb_valid,
  output logic [npc_pkg::REG_AW-1:0] o_wb_rd,
  output logic [`NPC_XLEN-1:0]       o_wb_data,
  output logic                       o_wb_we,
  output logic                       o_wb_illegal,
  input  wire                        i_wb_ready
);

  npc_pkg::dec_t dec, dec_q;
  npc_pkg::ex_t  ex, ex_q;
  npc_pkg::wb_t  wb;
  logic          dec_valid, dec_ready, decq_valid, decq_ready;
  logic          ex_valid, ex_ready, exq_valid, exq_ready;
  logic          wb_fire;

  // the register file and scoreboard see only records that actually leave.
  assign wb_fire = o_wb_valid && i_wb_ready;

  npc_idu u_idu (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_inst_valid(i_inst_valid), .o_inst_ready(o_inst_ready), .i_inst(i_inst),
    .i_wb(wb), .i_wb_fire(wb_fire),
    .o_valid(dec_valid), .i_ready(dec_ready), .o_dec(dec)
  );

  npc_pipe_reg #(.T(npc_pkg::dec_t)) u_dec_reg (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_valid(dec_valid), .o_ready(dec_ready), .i_data(dec),
    .o_valid(decq_valid), .i_ready(decq_ready), .o_data(dec_q)
  );

  npc_exu u_exu (
    .i_valid(decq_valid), .o_ready(decq_ready), .i_dec(dec_q),
    .o_valid(ex_valid), .i_ready(ex_ready), .o_ex(ex)
  );

  npc_pipe_reg #(.T(npc_pkg::ex_t)) u_ex_reg (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_valid(ex_valid), .o_ready(ex_ready), .i_data(ex),
    .o_valid(exq_valid), .i_ready(exq_ready), .o_data(ex_q)
  );

  npc_lsu u_lsu (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_valid(exq_valid), .o_ready(exq_ready), .i_ex(ex_q),
    .o_wb_valid(o_wb_valid), .i_wb_ready(i_wb_ready), .o_wb(wb)
  );

  assign o_wb_rd      = wb.rd;
  assign o_wb_data    = wb.data;
  assign o_wb_we      = wb.we;
  assign o_wb_illegal = wb.illegal;

endmodule

`default_nettype wire

//--- verif/npc_chk.sv
// watches only the handshakes at the core ports; values are left to the testbench model.
`timescale 1ns/1ps
`include "npc_params.svh"
`default_nettype none

module npc_chk (
  input wire                       i_clk,
  input wire                       i_rst,
  input wire                       i_inst_valid,
  input wire [31:0]                i_inst,
  input wire                       i_inst_ready,
  input wire                       i_wb_valid,
  input wire [npc_pkg::REG_AW-1:0] i_wb_rd,
  input wire [`NPC_XLEN-1:0]       i_wb_data,
  input wire                       i_wb_we,
  input wire                       i_wb_illegal,
  input wire                       i_wb_ready
);

  logic [npc_pkg::REG_AW+`NPC_XLEN+1:0] wb_rec;

  assign wb_rec = {i_wb_rd, i_wb_data, i_wb_we, i_wb_illegal};

  a_wb_idle: assert property (@(posedge i_clk) i_rst |=> !i_wb_valid)
    else $error("writeback valid is high in the cycle after reset");

  // a record that is not taken must wait unchanged.
  a_wb_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_wb_valid && !i_wb_ready) |=> (i_wb_valid && $stable(wb_rec)))
    else $error("stalled writeback record dropped or changed");

  a_inst_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_inst_valid && !i_inst_ready) |=> (i_inst_valid && $stable(i_inst)))
    else $error("instruction input dropped or changed before it was accepted");

endmodule

`default_nettype wire

//--- verif/npc_tb.sv
// fixed-seed random program; loads and stores use x8 as base, and random code writes x0 to x7 only.
`timescale 1ns/1ps
`include "npc_params.svh"
`default_nettype none

module npc_tb;

  localparam int RST_CYCLES = 8;
  localparam int N_RAND     = 200;
  localparam int N_BURST    = 16;

  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OP32  = 7'b0111011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;

  typedef struct packed {
    logic [4:0]  rd;
    logic [63:0] data;
    logic        we;
    logic        ill;
  } rec_t;

  logic        i_clk;
  logic        i_rst;
  logic        i_inst_valid;
  logic [31:0] i_inst;
  logic        o_inst_ready;
  logic        o_wb_valid;
  logic [4:0]  o_wb_rd;
  logic [63:0] o_wb_data;
  logic        o_wb_we;
  logic        o_wb_illegal;
  logic        i_wb_ready;

  logic [31:0] prog[$];
  rec_t        exp_q[$];
  logic [63:0] m_regs[32];
  logic [63:0] m_mem[`NPC_DMEM_WORDS];
  logic [63:0] m_pc;
  int          n_chk = 0;
  int          n_sent = 0;
  int          cyc = 0;
  int          burst_start = 0;
  int          first_cyc = 0;
  int          last_cyc = 0;
  int          val_errs = 0;
  int          other_errs = 0;
  bit          took = 1'b0;
  bit          burst = 1'b0;
  bit          prog_ready = 1'b0;

  npc_core UUT (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .o_inst_ready(o_inst_ready),
    .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
    .o_wb_we(o_wb_we), .o_wb_illegal(o_wb_illegal), .i_wb_ready(i_wb_ready)
  );

  bind npc_core npc_chk u_chk (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_inst_valid(i_inst_valid), .i_inst(i_inst), .i_inst_ready(o_inst_ready),
    .i_wb_valid(o_wb_valid), .i_wb_rd(o_wb_rd), .i_wb_data(o_wb_data),
    .i_wb_we(o_wb_we), .i_wb_illegal(o_wb_illegal), .i_wb_ready(i_wb_ready)
  );

  always #4 i_clk = ~i_clk;

  always @(posedge i_clk) cyc <= cyc + 1;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd,
                                        input logic [6:0] opc);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd,
                                        input logic [6:0] opc);
    return {imm, rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd,
                                        input logic [6:0] opc);
    return {imm, rd[4:0], opc};
  endfunction

  // mostly x1 to x4, so that neighbours often depend on each other.
  function automatic int pick_reg();
    if ($urandom_range(0, 3) != 0) return $urandom_range(1, 4);
    return $urandom_range(0, 7);
  endfunction

  function automatic logic [31:0] rand_inst();
    int          rd;
    int          rs1;
    int          rs2;
    int          dw_off;
    int          w_off;
    int          b_off;
    logic [31:0] inst;
    rd     = pick_reg();
    rs1    = pick_reg();
    rs2    = pick_reg();
    dw_off = int'($urandom_range(0, 31)) * 8 - 64; // x8 holds 64, so x8 + offset stays in 0..255.
    w_off  = int'($urandom_range(0, 63)) * 4 - 64;
    b_off  = int'($urandom_range(0, 255)) - 64;
    case ($urandom_range(0, 19))
      0:  inst = enc_i($urandom_range(0, 4095), rs1, 3'd0, rd, OPC_IMM);
      1:  inst = enc_i($urandom_range(0, 63), rs1, 3'd1, rd, OPC_IMM);
      2:  inst = enc_i($urandom_range(0, 63), rs1, 3'd5, rd, OPC_IMM);
      3:  inst = enc_r(7'h00, rs2, rs1, 3'd0, rd, OPC_OP);
      4:  inst = enc_r(7'h20, rs2, rs1, 3'd0, rd, OPC_OP);
      5:  inst = enc_r(7'h00, rs2, rs1, 3'd7, rd, OPC_OP);
      6:  inst = enc_r(7'h00, rs2, rs1, 3'd6, rd, OPC_OP);
      7:  inst = enc_r(7'h00, rs2, rs1, 3'd4, rd, OPC_OP);
      8:  inst = enc_r(7'h00, rs2, rs1, 3'd2, rd, OPC_OP);
      9:  inst = enc_r(7'h00, rs2, rs1, 3'd3, rd, OPC_OP);
      10: inst = enc_r(7'h00, rs2, rs1, 3'd0, rd, OPC_OP32);
      11: inst = enc_u($urandom, rd, OPC_LUI);
      12: inst = enc_u($urandom, rd, OPC_AUIPC);
      13: inst = enc_i(dw_off, 8, 3'd3, rd, OPC_LOAD);
      14: inst = enc_i(w_off, 8, 3'd2, rd, OPC_LOAD);
      15: inst = enc_i(b_off, 8, 3'd4, rd, OPC_LOAD);
      16: inst = enc_s(dw_off, rs2, 8, 3'd3);
      17: inst = enc_s(w_off, rs2, 8, 3'd2);
      18: inst = enc_s(b_off, rs2, 8, 3'd0);
      default: inst = ($urandom_range(0, 1) != 0) ? 32'h0 : enc_i(12'h403, rs1, 3'd5, rd, OPC_IMM);
    endcase
    return inst;
  endfunction

  // reference ISA step that executes one accepted instruction and queues its record.
  task automatic model_step(input logic [31:0] inst);
    logic [2:0]  f3;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] addr;
    logic [63:0] word;
    logic [63:0] sum;
    rec_t        r;
    f3     = inst[14:12];
    a      = m_regs[inst[19:15]];
    b      = m_regs[inst[24:20]];
    imm_i  = {{52{inst[31]}}, inst[31:20]};
    imm_u  = {{32{inst[31]}}, inst[31:12], 12'b0};
    r      = '{rd: inst[11:7], data: 64'd0, we: 1'b1, ill: 1'b0};
    case (inst[6:0])
      OPC_LUI:   r.data = imm_u;
      OPC_AUIPC: r.data = m_pc + imm_u;
      OPC_IMM: begin
        if (f3 == 3'd0) r.data = a + imm_i;
        else if (f3 == 3'd1 && inst[31:26] == 6'd0) r.data = a << inst[25:20];
        else if (f3 == 3'd5 && inst[31:26] == 6'd0) r.data = a >> inst[25:20];
        else r.ill = 1'b1;
      end
      OPC_OP: begin
        case ({inst[31:25], f3})
          {7'h00, 3'd0}: r.data = a + b;
          {7'h20, 3'd0}: r.data = a - b;
          {7'h00, 3'd2}: r.data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          {7'h00, 3'd3}: r.data = (a < b) ? 64'd1 : 64'd0;
          {7'h00, 3'd4}: r.data = a ^ b;
          {7'h00, 3'd6}: r.data = a | b;
          {7'h00, 3'd7}: r.data = a & b;
          default:       r.ill = 1'b1;
        endcase
      end
      OPC_OP32: begin
        sum    = a + b;
        r.data = {{32{sum[31]}}, sum[31:0]};
        if (inst[31:25] != 7'h00 || f3 != 3'd0) r.ill = 1'b1;
      end
      OPC_LOAD: begin
        addr = a + imm_i;
        word = m_mem[addr[7:3]];
        case (f3)
          3'd3:    r.data = word;
          3'd2:    r.data = addr[2] ? {{32{word[63]}}, word[63:32]} : {{32{word[31]}}, word[31:0]};
          3'd4:    r.data = {56'b0, word[8*addr[2:0] +: 8]};
          default: r.ill = 1'b1;
        endcase
      end
      7'b0100011: begin
        r.we = 1'b0;
        addr = a + {{52{inst[31]}}, inst[31:25], inst[11:7]};
        word = m_mem[addr[7:3]];
        case (f3)
          3'd3:    word = b;
          3'd2:    word[32*addr[2] +: 32] = b[31:0];
          3'd0:    word[8*addr[2:0] +: 8] = b[7:0];
          default: r.ill = 1'b1;
        endcase
        if (!r.ill) m_mem[addr[7:3]] = word;
      end
      default: r.ill = 1'b1;
    endcase
    if (r.ill) r.we = 1'b0;
    if (r.we && r.rd != 5'd0) m_regs[r.rd] = r.data; // x0 stays zero in the model too.
    m_pc = m_pc + 64'd4;
    exp_q.push_back(r);
  endtask

  task automatic check_record();
    rec_t e;
    if (exp_q.size() == 0) begin
      other_errs++;
      $display("writeback record at %0t arrived with no instruction outstanding", $time);
    end else begin
      e = exp_q.pop_front();
      if (o_wb_illegal !== e.ill) begin
        val_errs++;
        $display("Fail %0t: record %0d illegal expected %0b got %0b", $time, n_chk, e.ill,
                 o_wb_illegal);
      end
      if (o_wb_we !== e.we) begin
        val_errs++;
        $display("Fail %0t: record %0d we expected %0b got %0b", $time, n_chk, e.we, o_wb_we);
      end
      if (e.we && o_wb_rd !== e.rd) begin
        val_errs++;
        $display("Fail %0t: record %0d rd expected %0d got %0d", $time, n_chk, e.rd, o_wb_rd);
      end
      if (e.we && o_wb_data !== e.data) begin
        val_errs++;
        $display("Fail %0t: record %0d data expected %h got %h", $time, n_chk, e.data,
                 o_wb_data);
      end
      if (n_chk == burst_start + 4) first_cyc = cyc;
      if (n_chk == prog.size() - 1) last_cyc = cyc;
      n_chk++;
    end
  endtask

  // everything is sampled mid-cycle, where inputs and combinational outputs have settled.
  always @(negedge i_clk) begin
    if (!i_rst) begin
      took = i_inst_valid && o_inst_ready;
      if (took) begin
        model_step(i_inst);
      end
      if (o_wb_valid && i_wb_ready) check_record();
    end
  end

  initial begin
    wait (prog_ready);
    repeat (RST_CYCLES + 40 * prog.size()) @(posedge i_clk);
    $display("timeout: only %0d of %0d writeback records arrived", n_chk, prog.size());
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    i_clk        = 1'b0;
    i_rst        = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = 32'h0;
    i_wb_ready   = 1'b0;
    void'($urandom(32'h6560_11b4));
    m_pc = `NPC_RESET_PC;
    for (int i = 0; i < 32; i++) m_regs[i] = 64'd0;
    for (int i = 0; i < `NPC_DMEM_WORDS; i++) m_mem[i] = 64'd0;

    prog.push_back(enc_i(12'd64, 0, 3'd0, 8, OPC_IMM)); // x8 is the load and store base.
    prog.push_back(enc_i(12'hffb, 0, 3'd0, 1, OPC_IMM));
    prog.push_back(enc_u(20'h40001, 2, OPC_LUI));
    prog.push_back(enc_u(20'h12345, 3, OPC_AUIPC));
    prog.push_back(enc_i(12'd35, 1, 3'd1, 4, OPC_IMM));
    prog.push_back(enc_i(12'd60, 1, 3'd5, 5, OPC_IMM));
    prog.push_back(enc_r(7'h00, 2, 1, 3'd2, 6, OPC_OP));
    prog.push_back(enc_r(7'h00, 2, 1, 3'd3, 7, OPC_OP));
    prog.push_back(enc_r(7'h00, 2, 2, 3'd0, 6, OPC_OP32)); // carries into bit 31.
    prog.push_back(enc_r(7'h00, 4, 4, 3'd0, 4, OPC_OP));
    prog.push_back(enc_r(7'h20, 1, 4, 3'd0, 5, OPC_OP));
    prog.push_back(enc_s(12'd0, 1, 8, 3'd3));
    prog.push_back(enc_s(12'd12, 2, 8, 3'd2));
    prog.push_back(enc_s(12'd5, 3, 8, 3'd0));
    prog.push_back(enc_i(12'd0, 8, 3'd3, 4, OPC_LOAD));
    prog.push_back(enc_i(12'd12, 8, 3'd2, 5, OPC_LOAD));
    prog.push_back(enc_i(12'd8, 8, 3'd2, 6, OPC_LOAD));
    prog.push_back(enc_i(12'd5, 8, 3'd4, 7, OPC_LOAD));
    prog.push_back(enc_i(12'd7, 8, 3'd4, 4, OPC_LOAD));
    prog.push_back(enc_i(12'd8, 8, 3'd3, 5, OPC_LOAD));
    prog.push_back(enc_i(12'd123, 0, 3'd0, 0, OPC_IMM));
    prog.push_back(enc_r(7'h00, 0, 0, 3'd0, 1, OPC_OP));
    prog.push_back(32'h0000_0000);
    prog.push_back(32'hffff_ffff);
    prog.push_back(enc_i(12'h401, 1, 3'd5, 2, OPC_IMM));
    prog.push_back(enc_i(12'd1, 1, 3'd2, 3, OPC_IMM));
    prog.push_back(enc_r(7'h00, 0, 2, 3'd0, 2, OPC_OP));
    for (int k = 0; k < N_RAND; k++) prog.push_back(rand_inst());
    burst_start = prog.size();
    for (int k = 0; k < N_BURST; k++) prog.push_back(enc_i(k * 3 + 1, 0, 3'd0, 16 + k, OPC_IMM));
    prog_ready = 1'b1;

    repeat (RST_CYCLES) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    while (n_sent < prog.size()) begin
      @(posedge i_clk);
      #1;
      if (i_inst_valid && took) begin
        n_sent++;
        i_inst_valid = 1'b0;
      end
      burst      = (n_sent >= burst_start);
      i_wb_ready = burst || ($urandom_range(0, 3) != 0);
      if (!i_inst_valid && n_sent < prog.size() && (burst || $urandom_range(0, 2) != 0)) begin
        i_inst       = prog[n_sent];
        i_inst_valid = 1'b1;
      end
    end
    i_wb_ready = 1'b1;

    wait (n_chk == prog.size());
    repeat (5) @(posedge i_clk);
    if (last_cyc - first_cyc != N_BURST - 5) begin
      other_errs++;
      $display("burst records spread over %0d cycles instead of %0d", last_cyc - first_cyc,
               N_BURST - 5);
    end
    $display("errors: %0d value, %0d other; %0d of %0d records checked", val_errs, other_errs,
             n_chk, prog.size());
    if (val_errs + other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- npc.f
+incdir+design
design/npc_pkg.sv
design/npc_pipe_reg.sv
design/npc_idu.sv
design/npc_exu.sv
design/npc_lsu.sv
design/npc_core.sv
verif/npc_chk.sv
verif/npc_tb.sv

//--- Bender.yml
package:
  name: npc

export_include_dirs:
  - design

sources:
  - design/npc_pkg.sv
  - design/npc_pipe_reg.sv
  - design/npc_idu.sv
  - design/npc_exu.sv
  - design/npc_lsu.sv
  - design/npc_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/npc_chk.sv
      - verif/npc_tb.sv
